// ==== all.f ====
hdl/mmu_pkg.sv
hdl/axi_pkg.sv
hdl/ptw.sv
hdl/tlb.sv
hdl/mmu_top.sv
sim/axi_mem_model.sv
sim/tb_mmu_top.sv

// ==== hdl/axi_pkg.sv ====
package axi_pkg;

    // read response codes as carried on rresp
    typedef enum logic [1:0] {
        AXI_RESP_OKAY   = 2'b00,
        AXI_RESP_EXOKAY = 2'b01,
        AXI_RESP_SLVERR = 2'b10,
        AXI_RESP_DECERR = 2'b11
    } axi_resp_e;

    // 34 bit physical address space of sv32
    localparam int AXI_ADDR_W = 34;

    // one page table entry per beat
    // every walker read is a single beat of this width, so rlast comes with it
    localparam int AXI_DATA_W = 32;

endpackage

// ==== hdl/mmu_pkg.sv ====
package mmu_pkg;

    // sv32 address split
    // a virtual page number is two 10 bit table indices
    localparam int VPN_SLICE_W = 10;
    // physical page number of a 34 bit physical address
    localparam int PPN_W = 22;
    // flag byte at the bottom of every page table entry
    localparam int PTE_META_W = 8;

    typedef struct packed {
        // index into the root table
        logic [VPN_SLICE_W-1:0] vpn1;
        // index into the leaf table
        logic [VPN_SLICE_W-1:0] vpn0;
    } vpn_t;

    typedef logic [PPN_W-1:0] ppn_t;

    // v, r, w, x, u, g, a, d from bit 0 upwards
    typedef logic [PTE_META_W-1:0] pte_meta_t;

    // flag positions inside an entry
    localparam int PTE_V_BIT = 0;
    localparam int PTE_R_BIT = 1;
    localparam int PTE_W_BIT = 2;
    localparam int PTE_X_BIT = 3;

    // direct mapped translation cache
    localparam int TLB_ENTRIES = 16;
    localparam int TLB_INDEX_W = 4;
    // vpn bits left over after the index
    localparam int TLB_TAG_W = 16;

    // walker FSM
    typedef enum logic [1:0] {
        PTW_IDLE,
        PTW_AR,
        PTW_R,
        PTW_WALK
    } ptw_state_e;

    // cache controller FSM
    typedef enum logic [1:0] {
        TLB_IDLE,
        TLB_LOOKUP,
        TLB_WALK
    } tlb_state_e;

endpackage

// ==== hdl/mmu_top.sv ====
`timescale 1ns/1ps

module mmu_top
    import mmu_pkg::*;
    import axi_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    // core side
    input  logic                  translate_request,
    input  vpn_t                  translate_vpn,
    input  ppn_t                  satp_ppn,
    input  logic                  tlb_flush,
    output logic                  translate_done,
    output logic                  translate_pagefault,
    output logic                  translate_accessfault,
    output ppn_t                  translate_ppn,
    output pte_meta_t             translate_metadata,

    // axi read port of the walker
    output logic                  axi_arvalid,
    input  logic                  axi_arready,
    output logic [AXI_ADDR_W-1:0] axi_araddr,
    input  logic                  axi_rvalid,
    output logic                  axi_rready,
    input  axi_resp_e             axi_rresp,
    input  logic                  axi_rlast,
    input  logic [AXI_DATA_W-1:0] axi_rdata
);

    // cache to walker
    logic      resolve_request;
    vpn_t      virtual_address;

    // walker to cache
    logic      resolve_done;
    logic      resolve_pagefault;
    logic      resolve_accessfault;
    ppn_t      resolve_physical_address;
    pte_meta_t resolve_metadata;

    tlb u_tlb (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .translate_request        (translate_request),
        .translate_vpn            (translate_vpn),
        .satp_ppn                 (satp_ppn),
        .tlb_flush                (tlb_flush),
        .translate_done           (translate_done),
        .translate_pagefault      (translate_pagefault),
        .translate_accessfault    (translate_accessfault),
        .translate_ppn            (translate_ppn),
        .translate_metadata       (translate_metadata),
        .resolve_request          (resolve_request),
        .virtual_address          (virtual_address),
        .resolve_done             (resolve_done),
        .resolve_pagefault        (resolve_pagefault),
        .resolve_accessfault      (resolve_accessfault),
        .resolve_physical_address (resolve_physical_address),
        .resolve_metadata         (resolve_metadata)
    );

    // walker reads the root table named by satp directly
    ptw u_ptw (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .resolve_request          (resolve_request),
        .virtual_address          (virtual_address),
        .satp_ppn                 (satp_ppn),
        .axi_arvalid              (axi_arvalid),
        .axi_arready              (axi_arready),
        .axi_araddr               (axi_araddr),
        .axi_rvalid               (axi_rvalid),
        .axi_rready               (axi_rready),
        .axi_rresp                (axi_rresp),
        .axi_rlast                (axi_rlast),
        .axi_rdata                (axi_rdata),
        .resolve_done             (resolve_done),
        .resolve_pagefault        (resolve_pagefault),
        .resolve_accessfault      (resolve_accessfault),
        .resolve_metadata         (resolve_metadata),
        .resolve_physical_address (resolve_physical_address)
    );

endmodule

// ==== hdl/ptw.sv ====
`timescale 1ns/1ps

module ptw
    import mmu_pkg::*;
    import axi_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    // request from the translation cache
    input  logic                  resolve_request,
    input  vpn_t                  virtual_address,
    input  ppn_t                  satp_ppn,

    // axi read address channel
    output logic                  axi_arvalid,
    input  logic                  axi_arready,
    output logic [AXI_ADDR_W-1:0] axi_araddr,

    // axi read data channel
    input  logic                  axi_rvalid,
    output logic                  axi_rready,
    input  axi_resp_e             axi_rresp,
    input  logic                  axi_rlast,
    input  logic [AXI_DATA_W-1:0] axi_rdata,

    // walk result, valid with resolve_done only
    output logic                  resolve_done,
    output logic                  resolve_pagefault,
    output logic                  resolve_accessfault,
    output pte_meta_t             resolve_metadata,
    output ppn_t                  resolve_physical_address
);

    ptw_state_e state;
    ptw_state_e state_next;

    // 1 while reading the root table, 0 for the leaf table
    logic level;
    logic level_next;

    // base of the table being read
    ppn_t table_base;
    ppn_t table_base_next;

    // request and last entry read
    vpn_t                  saved_vpn;
    logic [AXI_DATA_W-1:0] saved_rdata;
    logic                  read_error;

    // decoded entry
    logic                         pte_valid;
    logic                         pte_read;
    logic                         pte_write;
    logic                         pte_execute;
    logic [PPN_W-VPN_SLICE_W-1:0] pte_ppn1;
    logic [VPN_SLICE_W-1:0]       pte_ppn0;
    logic                         pte_invalid;
    logic                         pte_leaf;
    logic                         pte_pointer;
    logic                         pte_misaligned;

    // table index for the current level
    logic [VPN_SLICE_W-1:0] vpn_slice;

    assign pte_valid   = saved_rdata[PTE_V_BIT];
    assign pte_read    = saved_rdata[PTE_R_BIT];
    assign pte_write   = saved_rdata[PTE_W_BIT];
    assign pte_execute = saved_rdata[PTE_X_BIT];
    assign pte_ppn1    = saved_rdata[AXI_DATA_W-1:AXI_DATA_W-(PPN_W-VPN_SLICE_W)];
    assign pte_ppn0    = saved_rdata[2*VPN_SLICE_W-1:VPN_SLICE_W];

    // w without r is a reserved encoding
    assign pte_invalid    = !pte_valid || (pte_write && !pte_read);
    assign pte_leaf       = pte_read || pte_execute;
    // v set, r w x clear
    assign pte_pointer    = pte_valid && !pte_read && !pte_write && !pte_execute;
    // a megapage must be 4 MiB aligned
    assign pte_misaligned = level && (pte_ppn0 != '0);

    assign vpn_slice  = level ? saved_vpn.vpn1 : saved_vpn.vpn0;
    assign axi_araddr = {table_base, vpn_slice, 2'b00};

    // handshakes come straight from the state
    assign axi_arvalid = (state == PTW_AR);
    assign axi_rready  = (state == PTW_R);

    // megapage keeps vpn0 as the page offset within the 4 MiB region
    assign resolve_physical_address = {pte_ppn1, level ? saved_vpn.vpn0 : pte_ppn0};
    assign resolve_metadata         = saved_rdata[PTE_META_W-1:0];

    always_comb begin
        state_next          = state;
        level_next          = level;
        table_base_next     = table_base;
        resolve_done        = 1'b0;
        resolve_pagefault   = 1'b0;
        resolve_accessfault = 1'b0;
        case (state)
            PTW_IDLE: begin
                // every walk starts at the root
                level_next      = 1'b1;
                table_base_next = satp_ppn;
                if (resolve_request) begin
                    state_next = PTW_AR;
                end
            end
            PTW_AR: begin
                if (axi_arready) begin
                    state_next = PTW_R;
                end
            end
            PTW_R: begin
                if (axi_rvalid) begin
                    state_next = PTW_WALK;
                end
            end
            PTW_WALK: begin
                if (read_error) begin
                    resolve_done        = 1'b1;
                    resolve_accessfault = 1'b1;
                end else if (pte_invalid) begin
                    resolve_done      = 1'b1;
                    resolve_pagefault = 1'b1;
                end else if (pte_leaf) begin
                    resolve_done      = 1'b1;
                    resolve_pagefault = pte_misaligned;
                end else if (pte_pointer && level) begin
                    // descend into the leaf table
                    level_next      = 1'b0;
                    table_base_next = saved_rdata[AXI_DATA_W-1:VPN_SLICE_W];
                    state_next      = PTW_AR;
                end else begin
                    // pointer where a leaf is required
                    resolve_done      = 1'b1;
                    resolve_pagefault = 1'b1;
                end
                if (resolve_done) begin
                    state_next = PTW_IDLE;
                end
            end
            default: begin
                state_next = PTW_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= PTW_IDLE;
            level <= 1'b1;
        end else begin
            state <= state_next;
            level <= level_next;
        end
    end

    always_ff @(posedge clk) begin
        table_base <= table_base_next;
        // vpn is sampled until the walk leaves idle
        if (state == PTW_IDLE) begin
            saved_vpn <= virtual_address;
        end
        // capture entry and response on the r handshake
        if (state == PTW_R && axi_rvalid) begin
            saved_rdata <= axi_rdata;
            read_error  <= (axi_rresp != AXI_RESP_OKAY);
        end
    end

    // address must not move or drop while the slave stalls
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr));

    // single beat reads only
    r_single_beat: assert property (@(posedge clk) disable iff (!rst_n)
        axi_rvalid && axi_rready |-> axi_rlast);

    fault_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        !(resolve_pagefault && resolve_accessfault));

    fault_with_done: assert property (@(posedge clk) disable iff (!rst_n)
        resolve_pagefault || resolve_accessfault |-> resolve_done);

endmodule

// ==== hdl/tlb.sv ====
`timescale 1ns/1ps

module tlb
    import mmu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // core side
    input  logic      translate_request,
    input  vpn_t      translate_vpn,
    input  ppn_t      satp_ppn,
    input  logic      tlb_flush,
    output logic      translate_done,
    output logic      translate_pagefault,
    output logic      translate_accessfault,
    output ppn_t      translate_ppn,
    output pte_meta_t translate_metadata,

    // walker side
    output logic      resolve_request,
    output vpn_t      virtual_address,
    input  logic      resolve_done,
    input  logic      resolve_pagefault,
    input  logic      resolve_accessfault,
    input  ppn_t      resolve_physical_address,
    input  pte_meta_t resolve_metadata
);

    tlb_state_e state;

    // vpn of the accepted request
    vpn_t req_vpn;

    // entry storage, only the valid bits are reset
    logic [TLB_ENTRIES-1:0] entry_valid;
    logic [TLB_TAG_W-1:0]   entry_tag [TLB_ENTRIES];
    ppn_t                   entry_ppn [TLB_ENTRIES];
    pte_meta_t              entry_meta [TLB_ENTRIES];

    // root table the cached entries were walked from
    ppn_t cache_root;

    logic [TLB_INDEX_W-1:0] req_index;
    logic [TLB_TAG_W-1:0]   req_tag;
    logic                   hit;
    logic                   refill;

    // low vpn0 bits pick the entry, the rest is the tag
    assign req_index = req_vpn.vpn0[TLB_INDEX_W-1:0];
    assign req_tag   = {req_vpn.vpn1, req_vpn.vpn0[VPN_SLICE_W-1:TLB_INDEX_W]};

    // entries from another root table never hit
    assign hit = entry_valid[req_index] && (entry_tag[req_index] == req_tag)
        && (cache_root == satp_ppn);

    // walker is idle during lookup and takes the request on this edge
    assign resolve_request = (state == TLB_LOOKUP) && !hit;
    assign virtual_address = req_vpn;

    // faults are not cached
    assign refill = (state == TLB_WALK) && resolve_done
        && !resolve_pagefault && !resolve_accessfault;

    always_comb begin
        if (state == TLB_WALK) begin
            // miss path, walker result goes straight through
            translate_done        = resolve_done;
            translate_pagefault   = resolve_pagefault;
            translate_accessfault = resolve_accessfault;
            translate_ppn         = resolve_physical_address;
            translate_metadata    = resolve_metadata;
        end else begin
            // hit path, one cycle after acceptance
            translate_done        = (state == TLB_LOOKUP) && hit;
            translate_pagefault   = 1'b0;
            translate_accessfault = 1'b0;
            translate_ppn         = entry_ppn[req_index];
            translate_metadata    = entry_meta[req_index];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= TLB_IDLE;
        end else begin
            case (state)
                TLB_IDLE: begin
                    if (translate_request) begin
                        state <= TLB_LOOKUP;
                    end
                end
                TLB_LOOKUP: begin
                    state <= hit ? TLB_IDLE : TLB_WALK;
                end
                TLB_WALK: begin
                    if (resolve_done) begin
                        state <= TLB_IDLE;
                    end
                end
                default: begin
                    state <= TLB_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == TLB_IDLE && translate_request) begin
            req_vpn <= translate_vpn;
        end
    end

    // flush wins over a refill on the same edge
    always_ff @(posedge clk) begin
        if (!rst_n || tlb_flush) begin
            entry_valid <= '0;
        end else if (refill) begin
            // new root table, drop what came from the old one
            if (cache_root != satp_ppn) begin
                entry_valid <= '0;
            end
            entry_valid[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill) begin
            entry_tag[req_index]  <= req_tag;
            entry_ppn[req_index]  <= resolve_physical_address;
            entry_meta[req_index] <= resolve_metadata;
            cache_root            <= satp_ppn;
        end
    end

    // no result leaves the cache without an accepted request
    done_not_idle: assert property (@(posedge clk) disable iff (!rst_n)
        state == TLB_IDLE |-> !translate_done);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the mmu testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f all.f --top-module tb_mmu_top -o tb_mmu_top
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_mmu_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "all tests passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// ==== sim/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model
    import axi_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  axi_arvalid,
    output logic                  axi_arready,
    input  logic [AXI_ADDR_W-1:0] axi_araddr,
    output logic                  axi_rvalid,
    input  logic                  axi_rready,
    output axi_resp_e             axi_rresp,
    output logic                  axi_rlast,
    output logic [AXI_DATA_W-1:0] axi_rdata
);

    // sparse storage by word address, absent words read as zero
    logic [AXI_DATA_W-1:0] words [logic [AXI_ADDR_W-3:0]];
    // words that answer with an error response
    logic                  error_words [logic [AXI_ADDR_W-3:0]];

    integer                seed;
    logic                  busy;
    logic [AXI_ADDR_W-3:0] read_addr;
    logic [1:0]            delay;

    function automatic void write_word(input logic [AXI_ADDR_W-3:0] addr,
                                       input logic [AXI_DATA_W-1:0] data);
        words[addr] = data;
    endfunction

    function automatic void set_error(input logic [AXI_ADDR_W-3:0] addr, input logic flag);
        error_words[addr] = flag;
    endfunction

    function automatic logic [AXI_DATA_W-1:0] read_word(input logic [AXI_ADDR_W-3:0] addr);
        if (words.exists(addr)) begin
            return words[addr];
        end
        return '0;
    endfunction

    function automatic logic read_error(input logic [AXI_ADDR_W-3:0] addr);
        if (error_words.exists(addr)) begin
            return error_words[addr];
        end
        return 1'b0;
    endfunction

    initial begin
        seed = 32'h134e_8dc0;
    end

    always @(posedge clk) begin
        integer r;
        r = $random(seed);
        if (!rst_n) begin
            axi_arready <= 1'b0;
            axi_rvalid  <= 1'b0;
            axi_rlast   <= 1'b0;
            axi_rresp   <= AXI_RESP_OKAY;
            axi_rdata   <= '0;
            busy        <= 1'b0;
            delay       <= 2'd0;
        end else if (!busy) begin
            if (axi_arvalid && axi_arready) begin
                // one outstanding read, address held until the beat goes out
                busy        <= 1'b1;
                axi_arready <= 1'b0;
                read_addr   <= axi_araddr[AXI_ADDR_W-1:2];
                delay       <= r[1:0];
            end else begin
                // ready comes and goes at random
                axi_arready <= r[2];
            end
        end else if (!axi_rvalid) begin
            if (delay == 2'd0) begin
                axi_rvalid <= 1'b1;
                axi_rlast  <= 1'b1;
                axi_rdata  <= read_word(read_addr);
                if (read_error(read_addr)) begin
                    axi_rresp <= r[3] ? AXI_RESP_DECERR : AXI_RESP_SLVERR;
                end else begin
                    axi_rresp <= AXI_RESP_OKAY;
                end
            end else begin
                delay <= delay - 2'd1;
            end
        end else if (axi_rready) begin
            axi_rvalid <= 1'b0;
            axi_rlast  <= 1'b0;
            busy       <= 1'b0;
        end
    end

endmodule

// ==== sim/tb_mmu_top.sv ====
`timescale 1ns/1ps

module tb_mmu_top
    import mmu_pkg::*;
    import axi_pkg::*;
();

    localparam ppn_t ROOT_PPN      = 22'h00400;
    localparam ppn_t LEAF_TABLE    = 22'h01000;
    localparam int   WAIT_LIMIT    = 200;
    localparam int   RANDOM_ROUNDS = 300;

    logic                  clk;
    logic                  rst_n;
    logic                  translate_request;
    vpn_t                  translate_vpn;
    ppn_t                  satp_ppn;
    logic                  tlb_flush;
    logic                  translate_done;
    logic                  translate_pagefault;
    logic                  translate_accessfault;
    ppn_t                  translate_ppn;
    pte_meta_t             translate_metadata;
    logic                  axi_arvalid;
    logic                  axi_arready;
    logic [AXI_ADDR_W-1:0] axi_araddr;
    logic                  axi_rvalid;
    logic                  axi_rready;
    axi_resp_e             axi_rresp;
    logic                  axi_rlast;
    logic [AXI_DATA_W-1:0] axi_rdata;

    integer seed;

    // expected cache contents, one slot per index
    logic model_valid [TLB_ENTRIES];
    vpn_t model_vpn [TLB_ENTRIES];

    // vpns reused in the random phase so that hits and evictions occur
    vpn_t pool [8];

    mmu_top u_dut (.*);

    axi_mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with(input string line);
        $display("%s", line);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_ppn(input ppn_t got, input ppn_t exp, input string what);
        if (got !== exp) begin
            stop_with($sformatf("CHECK FAILED at %0t ns: %s ppn %h, expected %h",
                $time, what, got, exp));
        end
    endtask

    task automatic check_meta(input pte_meta_t got, input pte_meta_t exp, input string what);
        if (got !== exp) begin
            stop_with($sformatf("CHECK FAILED at %0t ns: %s metadata %h, expected %h",
                $time, what, got, exp));
        end
    endtask

    // fault bits as {pagefault, accessfault}
    task automatic check_fault(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            stop_with($sformatf("CHECK FAILED at %0t ns: %s faults %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_with($sformatf("CHECK FAILED at %0t ns: %s is %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    function automatic logic [31:0] make_pte(input ppn_t ppn, input pte_meta_t flags);
        return {ppn, 2'b00, flags};
    endfunction

    task automatic put_entry(input ppn_t base, input logic [9:0] idx,
                             input logic [31:0] pte, input logic err);
        u_mem.write_word({base, idx}, pte);
        u_mem.set_error({base, idx}, err);
    endtask

    // sv32 walk over the memory model contents
    function automatic void ref_walk(input vpn_t vpn, input ppn_t root, output logic pf,
                                     output logic af, output ppn_t ppn, output pte_meta_t meta);
        logic [31:0] pte;
        logic [31:0] addr;
        ppn_t        base;
        pf   = 1'b0;
        af   = 1'b0;
        ppn  = '0;
        meta = '0;
        base = root;
        for (int lvl = 1; lvl >= 0; lvl--) begin
            addr = {base, (lvl == 1) ? vpn.vpn1 : vpn.vpn0};
            pte  = u_mem.read_word(addr);
            meta = pte[7:0];
            if (u_mem.read_error(addr)) begin
                af = 1'b1;
                return;
            end
            // invalid, or writable but not readable
            if (!pte[PTE_V_BIT] || (pte[PTE_W_BIT] && !pte[PTE_R_BIT])) begin
                pf = 1'b1;
                return;
            end
            if (pte[PTE_R_BIT] || pte[PTE_X_BIT]) begin
                ppn = (lvl == 1) ? {pte[31:20], vpn.vpn0} : pte[31:10];
                // megapage needs ppn0 clear
                pf  = (lvl == 1) && (pte[19:10] != 10'h000);
                return;
            end
            // pointer where a leaf must be
            if (lvl == 0) begin
                pf = 1'b1;
                return;
            end
            base = pte[31:10];
        end
    endfunction

    task automatic translate(input vpn_t vpn, output logic [1:0] fault, output ppn_t ppn,
                             output pte_meta_t meta, output int cycles, output logic ar_seen);
        logic finished;
        @(posedge clk);
        translate_request <= 1'b1;
        translate_vpn     <= vpn;
        cycles   = 0;
        ar_seen  = 1'b0;
        finished = 1'b0;
        // request not accepted yet at this falling edge
        @(negedge clk);
        while (!finished) begin
            @(negedge clk);
            cycles  = cycles + 1;
            ar_seen = ar_seen | axi_arvalid;
            if (translate_done) begin
                finished = 1'b1;
                fault    = {translate_pagefault, translate_accessfault};
                ppn      = translate_ppn;
                meta     = translate_metadata;
            end else if (cycles >= WAIT_LIMIT) begin
                stop_with($sformatf("no translation finished within %0d cycles for vpn %h",
                    WAIT_LIMIT, vpn));
            end
        end
        @(posedge clk);
        translate_request <= 1'b0;
    endtask

    task automatic expect_translation(input vpn_t vpn, input string what);
        logic                   exp_pf;
        logic                   exp_af;
        ppn_t                   exp_ppn;
        pte_meta_t              exp_meta;
        logic [1:0]             got_fault;
        ppn_t                   got_ppn;
        pte_meta_t              got_meta;
        int                     cycles;
        logic                   ar_seen;
        logic                   exp_hit;
        logic [TLB_INDEX_W-1:0] idx;
        ref_walk(vpn, ROOT_PPN, exp_pf, exp_af, exp_ppn, exp_meta);
        idx     = vpn.vpn0[TLB_INDEX_W-1:0];
        exp_hit = model_valid[idx] && (model_vpn[idx] == vpn);
        translate(vpn, got_fault, got_ppn, got_meta, cycles, ar_seen);
        // a hit answers one cycle after acceptance without touching memory
        check_flag(cycles == 1, exp_hit, {what, " hit"});
        check_flag(ar_seen, !exp_hit, {what, " arvalid seen"});
        check_fault(got_fault, {exp_pf, exp_af}, what);
        if (!exp_pf && !exp_af) begin
            check_ppn(got_ppn, exp_ppn, what);
            check_meta(got_meta, exp_meta, what);
            model_valid[idx] = 1'b1;
            model_vpn[idx]   = vpn;
        end
    endtask

    task automatic flush_cache();
        @(posedge clk);
        tlb_flush <= 1'b1;
        @(posedge clk);
        tlb_flush <= 1'b0;
        foreach (model_valid[i]) begin
            model_valid[i] = 1'b0;
        end
    endtask

    // kind 0 to 2 leaf, 3 to 5 pointer, 6 invalid, 7 w without r
    function automatic pte_meta_t random_flags(input logic [2:0] kind, input logic [31:0] r);
        logic [3:0] low;
        case (kind)
            3'd0, 3'd1: low = {r[8], r[9], 2'b11};
            3'd2:       low = 4'b1001;
            3'd3, 3'd4, 3'd5: low = 4'b0001;
            3'd6:       low = {r[8], r[9], r[10], 1'b0};
            default:    low = {r[8], 3'b101};
        endcase
        return {r[7:4], low};
    endfunction

    task automatic randomize_vpn(input vpn_t vpn);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        pte_meta_t   flags;
        ppn_t        ppn;
        ppn_t        table_ppn;
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        flags     = random_flags(r1[15:13], r1);
        // a few shared leaf tables
        table_ppn = {20'h00800, r1[17:16]};
        if (flags[3:0] == 4'b0001) begin
            ppn = table_ppn;
            put_entry(table_ppn, vpn.vpn0,
                make_pte({r3[31:20], r2[31:22]}, random_flags(r3[15:13], r3)),
                r3[19:16] == 4'h0);
        end else if (flags[PTE_R_BIT] || flags[PTE_X_BIT]) begin
            // megapage, misaligned about one time in four
            ppn = {r2[21:10], (r1[19:18] == 2'b00) ? r2[9:0] : 10'h000};
        end else begin
            ppn = r2[21:0];
        end
        put_entry(ROOT_PPN, vpn.vpn1, make_pte(ppn, flags), r1[23:20] == 4'h0);
    endtask

    initial begin
        logic [31:0] r;
        vpn_t        mega;
        vpn_t        page;
        seed              = 32'h134e_8dc0;
        rst_n             = 1'b0;
        translate_request = 1'b0;
        translate_vpn     = '0;
        satp_ppn          = ROOT_PPN;
        tlb_flush         = 1'b0;
        foreach (model_valid[i]) begin
            model_valid[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // megapage leaf at level 1
        put_entry(ROOT_PPN, 10'h001, make_pte(22'h2bc00, 8'hcf), 1'b0);
        mega = {10'h001, 10'h155};
        expect_translation(mega, "megapage");

        // pointer then 4 KiB leaf
        put_entry(ROOT_PPN, 10'h002, make_pte(LEAF_TABLE, 8'h01), 1'b0);
        put_entry(LEAF_TABLE, 10'h033, make_pte(22'h2a5a5, 8'h4b), 1'b0);
        page = {10'h002, 10'h033};
        expect_translation(page, "4k page");

        // page faults, root entry 3 is left empty
        expect_translation({10'h003, 10'h001}, "invalid entry");
        put_entry(ROOT_PPN, 10'h004, make_pte(22'h00003, 8'h05), 1'b0);
        expect_translation({10'h004, 10'h002}, "w without r");
        put_entry(ROOT_PPN, 10'h005, make_pte(22'h00011, 8'h03), 1'b0);
        expect_translation({10'h005, 10'h003}, "misaligned megapage");
        put_entry(LEAF_TABLE, 10'h034, make_pte(22'h00005, 8'h01), 1'b0);
        expect_translation({10'h002, 10'h034}, "pointer at level 0");

        // error responses on either level
        put_entry(ROOT_PPN, 10'h006, make_pte(22'h12c00, 8'h03), 1'b1);
        expect_translation({10'h006, 10'h004}, "level 1 read error");
        put_entry(LEAF_TABLE, 10'h035, make_pte(22'h00007, 8'h03), 1'b1);
        expect_translation({10'h002, 10'h035}, "level 0 read error");

        // repeats hit, faults walk again
        expect_translation(mega, "megapage again");
        expect_translation(page, "4k page again");
        expect_translation({10'h005, 10'h003}, "misaligned again");

        // new mapping becomes visible after a flush
        put_entry(ROOT_PPN, 10'h001, make_pte(22'h15400, 8'h0b), 1'b0);
        flush_cache();
        expect_translation(mega, "megapage after flush");

        // random tables, vpn1 8 to 15 stay clear of the entries above
        for (int i = 0; i < 8; i++) begin
            r       = $random(seed);
            pool[i] = {7'b0000001, r[2:0], r[17:8]};
            randomize_vpn(pool[i]);
        end
        for (int n = 0; n < RANDOM_ROUNDS; n++) begin
            r = $random(seed);
            if (r[4:2] == 3'd0) begin
                randomize_vpn(pool[r[10:8]]);
                flush_cache();
            end
            expect_translation(pool[r[10:8]], "random");
        end

        $display("all tests passed");
        $finish;
    end

endmodule
